//--- Makefile
SIM      := verilator
FLAGS    := --binary -j 0
TOP      := tb_io_subsystem
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
PASS_MSG := Regression passed

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- axil_io_bridge.sv
// AXI4-Lite slave bridge that serializes transactions into single I/O requests
`timescale 1ns/1ps

module axil_io_bridge (
    input  logic             clk,
    input  logic             rst_n,

    // Write address channel
    input  logic [15:0]      awaddr,
    input  logic             awvalid,
    output logic             awready,

    // Write data channel
    input  logic [31:0]      wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,

    // Write response channel
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  logic             bready,

    // Read address channel
    input  logic [15:0]      araddr,
    input  logic             arvalid,
    output logic             arready,

    // Read data channel
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  logic             rready,

    // I/O side
    output io_pkg::io_req_t  io_req,
    input  io_pkg::io_rsp_t  io_rsp
);

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t      state;

    // Latched request fields
    logic        req_we;
    logic [15:0] req_addr;
    logic [15:0] req_wdata;
    logic [1:0]  req_strb;

    // Captured response
    logic [15:0] rsp_data;
    logic [1:0]  rsp_code;

    // Handshake qualifiers
    logic        wr_go;
    logic        rd_go;

    // Write needs both AW and W present
    // Writes beat reads when both are pending
    assign wr_go = (state == ST_IDLE) && awvalid && wvalid;
    assign rd_go = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // Sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_go || rd_go) begin
                        state <= ST_ISSUE;
                    end
                end
                // Request is on the I/O side for this one cycle
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (io_rsp.valid) begin
                        state <= ST_RESP;
                    end
                end
                // Hold B or R until the master takes it
                ST_RESP: begin
                    if ((req_we && bready) || (!req_we && rready)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload capture at the handshake
    // Only the low half of the data bus and strobes 1:0 matter
    always_ff @(posedge clk) begin
        if (wr_go) begin
            req_we    <= 1'b1;
            req_addr  <= awaddr;
            req_wdata <= wdata[15:0];
            req_strb  <= wstrb[1:0];
        end else if (rd_go) begin
            req_we    <= 1'b0;
            req_addr  <= araddr;
            req_wdata <= '0;
            req_strb  <= '0;
        end
    end

    // Response payload capture, stable through ST_RESP
    always_ff @(posedge clk) begin
        if (state == ST_WAIT && io_rsp.valid) begin
            rsp_data <= io_rsp.data;
            rsp_code <= io_rsp.resp;
        end
    end

    // I/O request drive
    assign io_req.valid = (state == ST_ISSUE);
    assign io_req.we    = req_we;
    assign io_req.addr  = req_addr;
    assign io_req.wdata = req_wdata;
    assign io_req.strb  = req_strb;

    // AXI responses
    assign bvalid = (state == ST_RESP) && req_we;
    assign bresp  = rsp_code;
    assign rvalid = (state == ST_RESP) && !req_we;
    assign rresp  = rsp_code;
    // Upper read half is always zero
    assign rdata  = {16'h0000, rsp_data};

endmodule

//--- files.f
io_pkg.sv
axil_io_bridge.sv
io_address_decoder.sv
io_register_bank.sv
io_read_mux.sv
io_subsystem_top.sv
tb_io_subsystem.sv

//--- io_address_decoder.sv
// Port address window decoder producing one-hot bank selects and a default I/O flag
`timescale 1ns/1ps

module io_address_decoder #(
    parameter int                          NUM_BANKS  = 4,
    parameter int                          BANK_WORDS = 4,
    parameter logic [NUM_BANKS-1:0][15:0]  BANK_BASE  = io_pkg::DEFAULT_BANK_BASE
) (
    input  io_pkg::io_req_t         io_req,
    output logic [NUM_BANKS-1:0]    bank_sel,
    output logic                    default_hit
);

    // Window spans BANK_WORDS 16-bit words
    // Address bits from WIN_LSB upward identify the window
    localparam int WIN_LSB = $clog2(BANK_WORDS) + 1;

    // Set once any window has claimed the address
    logic hit;

    // Priority decode across all windows
    always_comb begin
        bank_sel    = '0;
        default_hit = 1'b0;
        hit         = 1'b0;

        // Nothing decodes without a live request
        if (io_req.valid) begin
            // Lowest bank index wins on overlap
            for (int i = 0; i < NUM_BANKS; i++) begin
                if (!hit && (io_req.addr[15:WIN_LSB] == BANK_BASE[i][15:WIN_LSB])) begin
                    bank_sel[i] = 1'b1;
                    hit         = 1'b1;
                end
            end

            // Unclaimed port goes to the default handler
            // Reads float high and writes are dropped there
            default_hit = !hit;
        end
    end

endmodule

//--- io_pkg.sv
// I/O subsystem package with request and response structs, AXI response codes, default port map
package io_pkg;

    // AXI response codes
    // Only OKAY and DECERR are ever produced by this subsystem
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Value seen on an undriven 16-bit ISA-style data bus
    // Pull-ups make every bit read as one
    localparam logic [15:0] FLOAT_BUS_DATA = 16'hFFFF;

    // Classic PC port map, one entry per register bank
    // Index 0 is checked first when windows overlap
    // Entry 0 is the PIC at 0x020
    // Entry 1 is the PIT at 0x040
    // Entry 2 is the PPI at 0x060
    // Entry 3 is the COM1 UART at 0x3F8
    localparam logic [3:0][15:0] DEFAULT_BANK_BASE = {
        16'h03F8,
        16'h0060,
        16'h0040,
        16'h0020
    };

    // One I/O request as issued by the bridge
    // Valid for exactly one cycle per transaction
    typedef struct packed {
        // Request strobe
        logic        valid;
        // High for OUT, low for IN
        logic        we;
        // Byte port address, bit 0 ignored downstream
        logic [15:0] addr;
        // Write data for OUT cycles
        logic [15:0] wdata;
        // Byte enables, bit 0 for the low byte
        logic [1:0]  strb;
    } io_req_t;

    // One response returned to the bridge
    // Data is zero for writes
    typedef struct packed {
        // Response strobe, one cycle wide
        logic        valid;
        // Read data
        logic [15:0] data;
        // AXI response code
        logic [1:0]  resp;
    } io_rsp_t;

endpackage

//--- io_read_mux.sv
// Read-return mux combining bank lanes and the floating-bus default into a registered response
`timescale 1ns/1ps

module io_read_mux #(
    parameter int NUM_BANKS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  io_pkg::io_req_t              io_req,
    input  logic [NUM_BANKS-1:0]         bank_sel,
    input  logic                         default_hit,
    input  logic [NUM_BANKS-1:0][15:0]   bank_rdata,
    output io_pkg::io_rsp_t              io_rsp
);

    // Selected bank data
    logic [15:0] mux_data;

    // AND-OR merge of the lanes
    // At most one select is high
    always_comb begin
        mux_data = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_sel[i]) begin
                mux_data = mux_data | bank_rdata[i];
            end
        end
    end

    // Response strobe, one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            io_rsp.valid <= 1'b0;
        end else begin
            io_rsp.valid <= io_req.valid;
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (io_req.valid) begin
            // Writes return zero data
            if (io_req.we) begin
                io_rsp.data <= '0;
            end else if (default_hit) begin
                io_rsp.data <= io_pkg::FLOAT_BUS_DATA;
            end else begin
                io_rsp.data <= mux_data;
            end
            io_rsp.resp <= default_hit ? io_pkg::RESP_DECERR : io_pkg::RESP_OKAY;
        end
    end

endmodule

//--- io_register_bank.sv
// Peripheral stand-in register window with byte-strobe writes and combinational readback
`timescale 1ns/1ps

module io_register_bank #(
    parameter int BANK_WORDS = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sel,
    input  io_pkg::io_req_t  io_req,
    output logic [15:0]      rdata
);

    // Word index width within the window
    localparam int IDX_W = $clog2(BANK_WORDS);

    // Register file
    logic [BANK_WORDS-1:0][15:0] regs;

    // Word index, address bit 0 dropped
    logic [IDX_W-1:0]            idx;

    // Write qualifier
    logic                        wr_en;

    assign idx   = io_req.addr[IDX_W:1];
    assign wr_en = sel && io_req.valid && io_req.we;

    // Register update
    // Each byte lane follows its own strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_en) begin
            // Low byte
            if (io_req.strb[0]) begin
                regs[idx][7:0] <= io_req.wdata[7:0];
            end
            // High byte
            if (io_req.strb[1]) begin
                regs[idx][15:8] <= io_req.wdata[15:8];
            end
        end
    end

    // Readback of the addressed word
    // Lane is qualified by sel in the read mux
    assign rdata = regs[idx];

endmodule

//--- io_subsystem_top.sv
// I/O port subsystem top with AXI4-Lite bridge, decoder, register banks and read mux
`timescale 1ns/1ps

module io_subsystem_top #(
    parameter int                          NUM_BANKS  = 4,
    parameter int                          BANK_WORDS = 4,
    parameter logic [NUM_BANKS-1:0][15:0]  BANK_BASE  = io_pkg::DEFAULT_BANK_BASE
) (
    input  logic         clk,
    input  logic         rst_n,

    // AXI4-Lite slave
    input  logic [15:0]  awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [31:0]  wdata,
    input  logic [3:0]   wstrb,
    input  logic         wvalid,
    output logic         wready,
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  logic         bready,
    input  logic [15:0]  araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rvalid,
    input  logic         rready
);

    // Internal request and response
    io_pkg::io_req_t              io_req;
    io_pkg::io_rsp_t              io_rsp;

    // Decode results
    logic [NUM_BANKS-1:0]         bank_sel;
    logic                         default_hit;

    // One readback lane per bank
    logic [NUM_BANKS-1:0][15:0]   bank_rdata;

    axil_io_bridge u_bridge (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .io_req  (io_req),
        .io_rsp  (io_rsp)
    );

    io_address_decoder #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS),
        .BANK_BASE  (BANK_BASE)
    ) u_decoder (
        .io_req      (io_req),
        .bank_sel    (bank_sel),
        .default_hit (default_hit)
    );

    // Peripheral windows, in port map order
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        io_register_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk    (clk),
            .rst_n  (rst_n),
            .sel    (bank_sel[i]),
            .io_req (io_req),
            .rdata  (bank_rdata[i])
        );
    end

    io_read_mux #(
        .NUM_BANKS (NUM_BANKS)
    ) u_read_mux (
        .clk         (clk),
        .rst_n       (rst_n),
        .io_req      (io_req),
        .bank_sel    (bank_sel),
        .default_hit (default_hit),
        .bank_rdata  (bank_rdata),
        .io_rsp      (io_rsp)
    );

endmodule

//--- tb_io_subsystem.sv
// Random-stimulus testbench for the I/O subsystem with a register model and compare tasks
`timescale 1ns/1ps

module tb_io_subsystem;

    // AXI response codes and wait limit in cycles
    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] DECERR  = 2'b11;
    localparam int         TIMEOUT = 50;

    // Model port map, PIC, PIT, PPI, UART from entry 0 up
    localparam logic [3:0][15:0] BASES = {16'h03F8, 16'h0060, 16'h0040, 16'h0020};

    logic        clk;
    logic        rst_n;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // Reference copy of every bank register
    logic [3:0][3:0][15:0] model;
    logic [31:0] rng_state;
    int          errors;
    int          checks;

    // Next request, raised early while a response still waits
    logic        raised;
    logic        nxt_we;
    logic [15:0] nxt_addr;
    logic [15:0] nxt_data;
    logic [1:0]  nxt_strb;

    // Port names match one to one
    io_subsystem_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // LCG with halves swapped so low bits are usable
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    // Bank index of a port address, -1 outside every 8-byte window
    function automatic int window_of(input logic [15:0] addr);
        for (int i = 0; i < 4; i++) begin
            if (addr[15:3] == BASES[2'(i)][15:3]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [15:0] mapped_addr(input logic [31:0] r);
        return BASES[r[17:16]] + {13'h0000, r[19:18], r[20]};
    endfunction

    // Bit 12 is clear in every base, so flipping it leaves all windows
    function automatic logic [15:0] unmapped_addr(input logic [31:0] r);
        logic [15:0] a;
        a = r[15:0];
        if (window_of(a) >= 0) begin
            a = a ^ 16'h1000;
        end
        return a;
    endfunction

    function automatic logic [33:0] payload(input logic we);
        return we ? {32'h0000_0000, bresp} : {rdata, rresp};
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_read(input logic [31:0] got, input logic [1:0] got_resp,
                              input logic [15:0] exp, input logic [1:0] exp_resp,
                              input logic [15:0] addr);
        checks++;
        if (got !== {16'h0000, exp} || got_resp !== exp_resp) begin
            flag_error($sformatf("read 0x%04h gave 0x%08h/%0d, expected 0x%08h/%0d",
                                 addr, got, got_resp, {16'h0000, exp}, exp_resp));
        end
    endtask

    task automatic check_write(input logic [1:0] got_resp, input logic [1:0] exp_resp,
                               input logic [15:0] addr);
        checks++;
        if (got_resp !== exp_resp) begin
            flag_error($sformatf("write 0x%04h gave bresp %0d, expected %0d",
                                 addr, got_resp, exp_resp));
        end
    endtask

    // Response must hold still and block new requests until accepted
    task automatic check_hold(input logic we, input logic [33:0] snap);
        checks++;
        if ((we ? bvalid : rvalid) !== 1'b1 || payload(we) !== snap) begin
            flag_error("response changed before acceptance");
        end
        if (awready || wready || arready) begin
            flag_error("ready raised while a response waits");
        end
    endtask

    // Upper data and strobe bits are random junk the DUT must ignore
    task automatic raise_req(input logic we, input logic [15:0] addr,
                             input logic [15:0] data, input logic [1:0] strb);
        logic [31:0] r;
        r = next_rand();
        if (we) begin
            awaddr  = addr;
            wdata   = {r[15:0], data};
            wstrb   = {r[17:16], strb};
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end else begin
            araddr  = addr;
            arvalid = 1'b1;
        end
    endtask

    // One full transaction, checked against the model, then the model is updated
    task automatic access(input logic we, input logic [15:0] addr, input logic [15:0] data,
                          input logic [1:0] strb, input int delay, input logic chain);
        int          win;
        int          cnt;
        logic [1:0]  bank;
        logic [15:0] exp_data;
        logic [1:0]  exp_resp;
        logic [33:0] snap;
        win      = window_of(addr);
        bank     = 2'(win);
        exp_resp = (win < 0) ? DECERR : OKAY;
        exp_data = (win < 0) ? 16'hFFFF : model[bank][addr[2:1]];
        if (!raised) begin
            @(negedge clk);
            raise_req(we, addr, data, strb);
        end
        raised = 1'b0;
        // Ready follows valid combinationally, so let it settle before sampling
        #1;
        // Ready seen mid-cycle means the transfer happens at the next rising edge
        cnt = 0;
        while (!(we ? (awready && wready) : arready)) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("the address handshake");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        cnt = 0;
        while (!(we ? bvalid : rvalid)) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("the response valid");
        end
        if (we ? rvalid : bvalid) begin
            flag_error("response on the wrong channel");
        end
        if (we) begin
            check_write(bresp, exp_resp, addr);
        end else begin
            check_read(rdata, rresp, exp_data, exp_resp, addr);
        end
        snap = payload(we);
        if (chain) begin
            raise_req(nxt_we, nxt_addr, nxt_data, nxt_strb);
            raised = 1'b1;
            // New valid settles before the ready lines are sampled
            #1;
        end
        repeat (delay) begin
            check_hold(we, snap);
            @(negedge clk);
        end
        check_hold(we, snap);
        if (we) begin
            bready = 1'b1;
        end else begin
            rready = 1'b1;
        end
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
        if (bvalid || rvalid) begin
            flag_error("second response after acceptance");
        end
        // Byte merge of a mapped write
        if (we && win >= 0) begin
            if (strb[0]) begin
                model[bank][addr[2:1]][7:0] = data[7:0];
            end
            if (strb[1]) begin
                model[bank][addr[2:1]][15:8] = data[15:8];
            end
        end
    endtask

    task automatic sweep_banks();
        for (int b = 0; b < 4; b++) begin
            for (int w = 0; w < 4; w++) begin
                access(1'b0, BASES[2'(b)] + 16'(2 * w), 16'h0000, 2'b00, 0, 1'b0);
            end
        end
    endtask

    // Mostly mapped, one in eight unmapped
    task automatic pick_next();
        logic [31:0] r;
        logic [31:0] d;
        r        = next_rand();
        d        = next_rand();
        nxt_we   = r[0];
        nxt_addr = (r[3:1] == 3'd0) ? unmapped_addr(d) : mapped_addr(r);
        nxt_data = d[31:16];
        nxt_strb = r[5:4];
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          mark;
        logic        cur_we;
        logic [15:0] cur_addr;
        logic [15:0] cur_data;
        logic [1:0]  cur_strb;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rng_state = 32'he5d7;
        model   = '0;
        errors  = 0;
        checks  = 0;
        raised  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        checks++;
        if (bvalid || rvalid) begin
            flag_error("bvalid or rvalid high after reset");
        end
        sweep_banks();
        report_test("reset values", mark);

        mark = errors;
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            d = next_rand();
            access(r[0], mapped_addr(r), d[31:16], 2'b11, 0, 1'b0);
        end
        report_test("full strobes", mark);

        // Strobe codes 00, 01 and 10 only
        mark = errors;
        for (int i = 0; i < 150; i++) begin
            r = next_rand();
            d = next_rand();
            access(r[0], mapped_addr(r), d[31:16], 2'(d % 3), 0, 1'b0);
        end
        report_test("partial strobes", mark);

        mark = errors;
        for (int i = 0; i < 50; i++) begin
            r = next_rand();
            d = next_rand();
            access(r[0], unmapped_addr(d), r[31:16], 2'b11, 0, 1'b0);
        end
        sweep_banks();
        report_test("default I/O", mark);

        mark = errors;
        pick_next();
        for (int i = 0; i < 200; i++) begin
            cur_we   = nxt_we;
            cur_addr = nxt_addr;
            cur_data = nxt_data;
            cur_strb = nxt_strb;
            pick_next();
            access(cur_we, cur_addr, cur_data, cur_strb, int'(next_rand() % 7), i < 199);
        end
        report_test("back-pressure", mark);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
